// File: hdl/bus_frame_pkg.sv
`default_nettype none

package bus_frame_pkg;

    // control frame layout: start code, slave id, read/write bit
    localparam int START_WIDTH = 3;
    localparam int ID_WIDTH    = 2;
    localparam int FRAME_LEN   = START_WIDTH + ID_WIDTH + 1;

    localparam logic [START_WIDTH-1:0] START_CODE = {START_WIDTH{1'b1}};

    // master side data path
    localparam int DATA_WIDTH   = 32;
    localparam int STATUS_WIDTH = 4;

    // status nibble followed by the data word on rD
    localparam int STREAM_LEN = STATUS_WIDTH + DATA_WIDTH;

    typedef logic [DATA_WIDTH-1:0]   data_word_t;
    typedef logic [ID_WIDTH-1:0]     slave_id_t;
    typedef logic [STATUS_WIDTH-1:0] link_status_t;

    // no write outcome known yet
    localparam link_status_t STATUS_NONE = '0;

    // one-cycle command from the frame decoder
    typedef struct packed {
        logic strobe;
        logic is_write;
    } cmd_t;

    typedef enum logic [1:0] {
        FR_IDLE,
        FR_SHIFT,
        FR_BUSY
    } frame_state_t;

endpackage

`default_nettype wire

// File: hdl/frame_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module frame_decoder #(
    parameter bus_frame_pkg::slave_id_t SLAVE_ID = 1
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic                control,
    input  logic                release_cmd,
    output bus_frame_pkg::cmd_t cmd,
    output logic                busy
);

    bus_frame_pkg::frame_state_t state;

    // bits collected so far with the newest in bit 0
    logic [bus_frame_pkg::FRAME_LEN-2:0]          shreg;
    logic [$clog2(bus_frame_pkg::FRAME_LEN)-1:0]  bit_cnt;

    // full frame once the current control bit is appended
    logic [bus_frame_pkg::FRAME_LEN-1:0] frame;
    logic                                start_ok;
    logic                                id_ok;

    assign frame = {shreg, control};

    assign start_ok = frame[bus_frame_pkg::FRAME_LEN-1 -: bus_frame_pkg::START_WIDTH]
                      == bus_frame_pkg::START_CODE;
    assign id_ok    = frame[bus_frame_pkg::ID_WIDTH:1] == SLAVE_ID;

    assign busy = (state == bus_frame_pkg::FR_BUSY);

    always_ff @(posedge clk) begin
        if (state != bus_frame_pkg::FR_BUSY) begin
            shreg <= frame[bus_frame_pkg::FRAME_LEN-2:0];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= bus_frame_pkg::FR_IDLE;
            bit_cnt <= '0;
            cmd     <= '0;
        end else begin
            cmd.strobe <= 1'b0;
            case (state)
                bus_frame_pkg::FR_IDLE: begin
                    // first start bit opens a frame
                    if (control) begin
                        bit_cnt <= 1;
                        state   <= bus_frame_pkg::FR_SHIFT;
                    end
                end
                bus_frame_pkg::FR_SHIFT: begin
                    if (bit_cnt == bus_frame_pkg::FRAME_LEN - 1) begin
                        bit_cnt <= '0;
                        if (start_ok && id_ok) begin
                            cmd.strobe   <= 1'b1;
                            cmd.is_write <= frame[0];
                            state        <= bus_frame_pkg::FR_BUSY;
                        end else begin
                            state <= bus_frame_pkg::FR_IDLE;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                bus_frame_pkg::FR_BUSY: begin
                    // control is ignored until the engine finishes
                    if (release_cmd) begin
                        state <= bus_frame_pkg::FR_IDLE;
                    end
                end
                default: state <= bus_frame_pkg::FR_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/read_responder.sv
`timescale 1ns/1ps
`default_nettype none

module read_responder (
    input  logic                        clk,
    input  logic                        rstN,
    input  bus_frame_pkg::cmd_t         cmd,
    input  bus_frame_pkg::link_status_t status,
    input  logic                        g_txReady,
    input  uart_link_pkg::uart_rx_t     g_rx,
    output uart_link_pkg::uart_tx_t     g_tx,
    output logic                        rD,
    output logic                        ready_req,
    output logic                        done
);

    uart_link_pkg::read_state_t state;

    // status nibble above the captured word, shifted out from the top
    logic [bus_frame_pkg::STREAM_LEN-1:0]         out_sr;
    logic [$clog2(bus_frame_pkg::STREAM_LEN)-1:0] bit_cnt;

    logic start_read;
    logic streaming;

    assign start_read = cmd.strobe && !cmd.is_write;
    assign streaming  = (state == uart_link_pkg::R_STREAM);

    // ACK byte back to the previous board
    assign g_tx.start = (state == uart_link_pkg::R_SEND_ACK) && g_txReady;
    assign g_tx.data  = bus_frame_pkg::data_word_t'(uart_link_pkg::ACK_CODE);

    assign ready_req = streaming;
    // rD stays low outside the window
    assign rD        = streaming && out_sr[bus_frame_pkg::STREAM_LEN-1];

    always_ff @(posedge clk) begin
        if (state == uart_link_pkg::R_WAIT_RX && g_rx.done) begin
            out_sr <= {status, g_rx.data};
        end else if (streaming) begin
            out_sr <= {out_sr[bus_frame_pkg::STREAM_LEN-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= uart_link_pkg::R_IDLE;
            bit_cnt <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                uart_link_pkg::R_IDLE: begin
                    if (start_read) begin
                        state <= uart_link_pkg::R_WAIT_RX;
                    end
                end
                uart_link_pkg::R_WAIT_RX: begin
                    // word from the get link
                    if (g_rx.done) begin
                        state <= uart_link_pkg::R_SEND_ACK;
                    end
                end
                uart_link_pkg::R_SEND_ACK: begin
                    if (g_txReady) begin
                        bit_cnt <= '0;
                        state   <= uart_link_pkg::R_STREAM;
                    end
                end
                uart_link_pkg::R_STREAM: begin
                    if (bit_cnt == bus_frame_pkg::STREAM_LEN - 1) begin
                        done  <= 1'b1;
                        state <= uart_link_pkg::R_IDLE;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= uart_link_pkg::R_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/uart_link_pkg.sv
`default_nettype none

package uart_link_pkg;

    typedef logic [7:0] link_byte_t;

    localparam link_byte_t ACK_CODE = 8'hCC;
    localparam link_byte_t NAK_CODE = 8'hAA;

    // status nibbles reported to the master
    localparam bus_frame_pkg::link_status_t ACK_STATUS = ACK_CODE[7:4];
    localparam bus_frame_pkg::link_status_t NAK_STATUS = NAK_CODE[7:4];

    // short timeout, simulation friendly
    localparam int ACK_TIMEOUT      = 64;
    localparam int RETRANSMIT_LIMIT = 3;

    // slave to transmitter
    typedef struct packed {
        logic                     start;
        bus_frame_pkg::data_word_t data;
    } uart_tx_t;

    // receiver to slave
    typedef struct packed {
        logic                     done;
        bus_frame_pkg::data_word_t data;
    } uart_rx_t;

    typedef enum logic [1:0] {
        W_IDLE,
        W_COLLECT,
        W_SEND,
        W_WAIT_ACK
    } write_state_t;

    typedef enum logic [1:0] {
        R_IDLE,
        R_WAIT_RX,
        R_SEND_ACK,
        R_STREAM
    } read_state_t;

endpackage

`default_nettype wire

// File: hdl/uart_slave.sv
`timescale 1ns/1ps
`default_nettype none

module uart_slave #(
    parameter bus_frame_pkg::slave_id_t SLAVE_ID = 1
) (
    input  logic                      clk,
    input  logic                      rstN,
    // master side
    input  logic                      control,
    input  logic                      wD,
    input  logic                      valid,
    output logic                      rD,
    output logic                      ready,
    // send link
    output uart_link_pkg::uart_tx_t   s_tx,
    input  logic                      s_txReady,
    input  uart_link_pkg::uart_rx_t   s_rx,
    // get link
    output uart_link_pkg::uart_tx_t   g_tx,
    input  logic                      g_txReady,
    input  uart_link_pkg::uart_rx_t   g_rx
);

    bus_frame_pkg::cmd_t         cmd;
    bus_frame_pkg::link_status_t status;

    logic dec_busy;
    logic w_ready_req;
    logic w_done;
    logic r_ready_req;
    logic r_done;

    frame_decoder #(
        .SLAVE_ID   (SLAVE_ID)
    ) u_decoder (
        .clk        (clk),
        .rstN       (rstN),
        .control    (control),
        .release_cmd(w_done | r_done),
        .cmd        (cmd),
        .busy       (dec_busy)
    );

    write_forwarder u_write (
        .clk        (clk),
        .rstN       (rstN),
        .cmd        (cmd),
        .wD         (wD),
        .valid      (valid),
        .s_txReady  (s_txReady),
        .s_rx       (s_rx),
        .s_tx       (s_tx),
        .ready_req  (w_ready_req),
        .done       (w_done),
        .status     (status)
    );

    read_responder u_read (
        .clk        (clk),
        .rstN       (rstN),
        .cmd        (cmd),
        .status     (status),
        .g_txReady  (g_txReady),
        .g_rx       (g_rx),
        .g_tx       (g_tx),
        .rD         (rD),
        .ready_req  (r_ready_req),
        .done       (r_done)
    );

    // idle slave reports ready, otherwise the engine of the held command does
    assign ready = dec_busy ? (cmd.is_write ? w_ready_req : r_ready_req) : 1'b1;

endmodule

`default_nettype wire

// File: hdl/write_forwarder.sv
`timescale 1ns/1ps
`default_nettype none

module write_forwarder (
    input  logic                        clk,
    input  logic                        rstN,
    input  bus_frame_pkg::cmd_t         cmd,
    input  logic                        wD,
    input  logic                        valid,
    input  logic                        s_txReady,
    input  uart_link_pkg::uart_rx_t     s_rx,
    output uart_link_pkg::uart_tx_t     s_tx,
    output logic                        ready_req,
    output logic                        done,
    output bus_frame_pkg::link_status_t status
);

    uart_link_pkg::write_state_t state;

    bus_frame_pkg::data_word_t word;
    logic [$clog2(bus_frame_pkg::DATA_WIDTH)-1:0]         bit_cnt;
    logic [$clog2(uart_link_pkg::ACK_TIMEOUT)-1:0]        ack_timer;
    logic [$clog2(uart_link_pkg::RETRANSMIT_LIMIT+1)-1:0] retx_cnt;

    uart_link_pkg::link_byte_t rx_byte;
    logic                      start_write;

    assign rx_byte     = s_rx.data[7:0];
    assign start_write = cmd.strobe && cmd.is_write;

    // ready already high in the command cycle so the master sees no gap
    assign ready_req = (state == uart_link_pkg::W_COLLECT) || start_write;

    // start only while the transmitter can take it
    assign s_tx.start = (state == uart_link_pkg::W_SEND) && s_txReady;
    assign s_tx.data  = word;

    // write word, MSB first
    always_ff @(posedge clk) begin
        if (state == uart_link_pkg::W_COLLECT && valid) begin
            word <= {word[bus_frame_pkg::DATA_WIDTH-2:0], wD};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= uart_link_pkg::W_IDLE;
            bit_cnt   <= '0;
            ack_timer <= '0;
            retx_cnt  <= '0;
            done      <= 1'b0;
            status    <= bus_frame_pkg::STATUS_NONE;
        end else begin
            done <= 1'b0;
            case (state)
                uart_link_pkg::W_IDLE: begin
                    if (start_write) begin
                        bit_cnt  <= '0;
                        retx_cnt <= '0;
                        state    <= uart_link_pkg::W_COLLECT;
                    end
                end
                uart_link_pkg::W_COLLECT: begin
                    if (valid) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == bus_frame_pkg::DATA_WIDTH - 1) begin
                            state <= uart_link_pkg::W_SEND;
                        end
                    end
                end
                uart_link_pkg::W_SEND: begin
                    // held here while the link is back-pressured
                    if (s_txReady) begin
                        ack_timer <= '0;
                        state     <= uart_link_pkg::W_WAIT_ACK;
                    end
                end
                uart_link_pkg::W_WAIT_ACK: begin
                    if (s_rx.done) begin
                        // anything but the ACK byte counts as NAK
                        status <= (rx_byte == uart_link_pkg::ACK_CODE) ?
                                  uart_link_pkg::ACK_STATUS : uart_link_pkg::NAK_STATUS;
                        done   <= 1'b1;
                        state  <= uart_link_pkg::W_IDLE;
                    end else if (ack_timer == uart_link_pkg::ACK_TIMEOUT - 1) begin
                        if (retx_cnt < uart_link_pkg::RETRANSMIT_LIMIT) begin
                            retx_cnt <= retx_cnt + 1'b1;
                            state    <= uart_link_pkg::W_SEND;
                        end else begin
                            // retries used up
                            status <= uart_link_pkg::NAK_STATUS;
                            done   <= 1'b1;
                            state  <= uart_link_pkg::W_IDLE;
                        end
                    end else begin
                        ack_timer <= ack_timer + 1'b1;
                    end
                end
                default: state <= uart_link_pkg::W_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release just after an edge, like the other inputs
    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

// File: verification/uart_slave_chk.sv
`timescale 1ns/1ps
`default_nettype none

module uart_slave_chk (
    input logic                    clk,
    input logic                    rstN,
    input logic                    ready,
    input uart_link_pkg::uart_tx_t s_tx,
    input logic                    s_txReady,
    input uart_link_pkg::uart_tx_t g_tx,
    input logic                    g_txReady
);

    int fail_count = 0;

    s_start_pulse: assert property (@(posedge clk) disable iff (!rstN)
        s_tx.start |=> !s_tx.start)
        else begin
            $error("s_tx.start lasted more than one cycle");
            fail_count++;
        end

    g_start_pulse: assert property (@(posedge clk) disable iff (!rstN)
        g_tx.start |=> !g_tx.start)
        else begin
            $error("g_tx.start lasted more than one cycle");
            fail_count++;
        end

    s_start_ready: assert property (@(posedge clk) disable iff (!rstN)
        s_tx.start |-> s_txReady)
        else begin
            $error("s_tx.start while s_txReady low");
            fail_count++;
        end

    g_start_ready: assert property (@(posedge clk) disable iff (!rstN)
        g_tx.start |-> g_txReady)
        else begin
            $error("g_tx.start while g_txReady low");
            fail_count++;
        end

    ready_after_reset: assert property (@(posedge clk) $rose(rstN) |=> ready)
        else begin
            $error("ready low one cycle after reset release");
            fail_count++;
        end

    // status nibble plus data word, then the done cycle
    stream_window: assert property (@(posedge clk) disable iff (!rstN)
        g_tx.start |=> ready [*bus_frame_pkg::STREAM_LEN] ##1 !ready)
        else begin
            $error("ready window after g_tx.start has the wrong length");
            fail_count++;
        end

endmodule

bind uart_slave uart_slave_chk u_chk (
    .clk      (clk),
    .rstN     (rstN),
    .ready    (ready),
    .s_tx     (s_tx),
    .s_txReady(s_txReady),
    .g_tx     (g_tx),
    .g_txReady(g_txReady)
);

`default_nettype wire

// File: verification/uart_slave_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_slave_tb;

    // status nibbles seen on rD
    localparam logic [3:0] ACK_NIBBLE = 4'b1100;
    localparam logic [3:0] NAK_NIBBLE = 4'b1010;
    localparam int         STREAM_LEN = 36;

    logic clk;
    logic rstN;
    logic control;
    logic wD;
    logic valid;
    logic rD;
    logic ready;
    logic s_txReady;
    logic g_txReady;
    logic ack_enable;

    uart_link_pkg::uart_tx_t   s_tx;
    uart_link_pkg::uart_rx_t   s_rx;
    uart_link_pkg::uart_tx_t   g_tx;
    uart_link_pkg::uart_rx_t   g_rx;
    bus_frame_pkg::data_word_t s_last_data;
    bus_frame_pkg::data_word_t g_last_data;

    integer seed = 32'hc760;
    int     error_count = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     ack_wait = 0;
    int     s_start_count = 0;
    int     g_start_count = 0;

    tb_clock_gen u_clk_gen (
        .clk (clk),
        .rstN(rstN)
    );

    uart_slave #(
        .SLAVE_ID (1)
    ) UUT (
        .clk      (clk),
        .rstN     (rstN),
        .control  (control),
        .wD       (wD),
        .valid    (valid),
        .rD       (rD),
        .ready    (ready),
        .s_tx     (s_tx),
        .s_txReady(s_txReady),
        .s_rx     (s_rx),
        .g_tx     (g_tx),
        .g_txReady(g_txReady),
        .g_rx     (g_rx)
    );

    // neighbouring boards watch both transmitters mid cycle
    always @(negedge clk) begin
        if (rstN && s_tx.start) begin
            s_start_count++;
            s_last_data = s_tx.data;
            if (ack_enable) begin
                ack_wait = 4;
            end
        end
        if (rstN && g_tx.start) begin
            g_start_count++;
            g_last_data = g_tx.data;
        end
    end

    // ACK reply on the send link receiver
    always @(posedge clk) begin
        #1;
        s_rx.done = (ack_wait == 1);
        s_rx.data = bus_frame_pkg::data_word_t'(uart_link_pkg::ACK_CODE);
        if (ack_wait > 0) begin
            ack_wait--;
        end
    end

    task automatic drive_slot();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        assert (actual === expected)
        else begin
            $display("mismatch at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic wait_ready(input logic level, input int limit, input string what,
                              output logic ok);
        int n;
        ok = 1'b0;
        n = 0;
        while (!ok && n < limit) begin
            @(negedge clk);
            ok = (ready === level);
            n++;
        end
        if (!ok) begin
            $display("timeout at %0t ns: ready never went %0b during %s", $time, level, what);
            error_count++;
        end
    endtask

    task automatic send_frame(input bus_frame_pkg::slave_id_t id, input logic is_write);
        logic [5:0] bits;
        int i;
        bits = {3'b111, id, is_write};
        for (i = 5; i >= 0; i--) begin
            drive_slot();
            control = bits[i];
        end
        drive_slot();
        control = 1'b0;
    endtask

    task automatic write_word(input bus_frame_pkg::data_word_t word, input int limit);
        int i;
        logic ok;
        send_frame(2'd1, 1'b1);
        for (i = 31; i >= 0; i--) begin
            drive_slot();
            valid = 1'b1;
            wD    = word[i];
        end
        drive_slot();
        valid = 1'b0;
        wD    = 1'b0;
        wait_ready(1'b0, 5, "hand-off to the send link", ok);
        if (ok) begin
            wait_ready(1'b1, limit, "the write outcome", ok);
        end
    endtask

    task automatic read_and_check(input logic [3:0] nibble);
        bus_frame_pkg::data_word_t     word;
        logic [STREAM_LEN-1:0]         expected;
        int                            g_before;
        int                            k;
        logic                          ok;
        word     = $random(seed);
        expected = {nibble, word};
        g_before = g_start_count;
        send_frame(2'd1, 1'b0);
        wait_ready(1'b0, 5, "the read command", ok);
        if (ok) begin
            drive_slot();
            g_rx.done = 1'b1;
            g_rx.data = word;
            drive_slot();
            g_rx.done = 1'b0;
            wait_ready(1'b1, 20, "start of the rD stream", ok);
        end
        if (ok) begin
            for (k = 0; k < STREAM_LEN; k++) begin
                if (k > 0) begin
                    @(negedge clk);
                end
                check_value(ready, 1'b1, "ready inside the stream window");
                check_value(rD, expected[STREAM_LEN-1-k], $sformatf("rD bit %0d", k));
            end
            @(negedge clk);
            check_value(ready, 1'b0, "ready after the stream window");
            check_value(g_start_count - g_before, 1, "g_tx.start count");
            check_value(g_last_data[7:0], 8'hCC, "ACK byte on g_tx");
            wait_ready(1'b1, 5, "return to idle after the read", ok);
        end
    endtask

    task automatic checked_write(input int expected_starts, input int limit);
        bus_frame_pkg::data_word_t word;
        int s_before;
        word     = $random(seed);
        s_before = s_start_count;
        write_word(word, limit);
        check_value(s_start_count - s_before, expected_starts, "s_tx.start count");
        check_value(s_last_data, word, "s_tx.data");
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (error_count == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, error_count - errs_before);
        end
    endtask

    initial begin
        int   errs;
        int   n;
        logic ok;
        control    = 1'b0;
        wD         = 1'b0;
        valid      = 1'b0;
        s_txReady  = 1'b1;
        g_txReady  = 1'b1;
        s_rx       = '0;
        g_rx       = '0;
        ack_enable = 1'b1;

        errs = error_count;
        ok   = 1'b0;
        n    = 0;
        while (!ok && n < 50) begin
            @(negedge clk);
            ok = rstN;
            n++;
        end
        if (!ok) begin
            $display("timeout at %0t ns: reset was never released", $time);
            error_count++;
        end
        check_value(ready, 1'b1, "ready after reset");
        check_value(rD, 1'b0, "rD after reset");
        check_value(s_start_count + g_start_count, 0, "starts after reset");
        report_test("reset state", errs);

        errs = error_count;
        checked_write(1, 200);
        report_test("acknowledged write", errs);

        // a wrongly accepted read would drop ready while it waits on the get link
        errs = error_count;
        n    = s_start_count + g_start_count;
        send_frame(2'd2, 1'b0);
        repeat (100) begin
            @(negedge clk);
            check_value(ready, 1'b1, "ready during a frame for another id");
        end
        check_value(s_start_count + g_start_count, n, "starts for another id");
        report_test("frame for another id", errs);

        // silent send link so every retransmission times out
        errs       = error_count;
        ack_enable = 1'b0;
        checked_write(1 + uart_link_pkg::RETRANSMIT_LIMIT, 600);
        ack_enable = 1'b1;
        read_and_check(NAK_NIBBLE);
        report_test("retransmit then NAK read", errs);

        errs = error_count;
        checked_write(1, 200);
        read_and_check(ACK_NIBBLE);
        report_test("acknowledged write then read", errs);

        repeat (5) @(negedge clk);
        $display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, error_count, UUT.u_chk.fail_count);
        if (tests_failed == 0 && error_count == 0 && UUT.u_chk.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
hdl/bus_frame_pkg.sv
hdl/uart_link_pkg.sv
hdl/frame_decoder.sv
hdl/write_forwarder.sv
hdl/read_responder.sv
hdl/uart_slave.sv
verification/tb_clock_gen.sv
verification/uart_slave_chk.sv
verification/uart_slave_tb.sv
